// ==== project.f ====
hw/msr_pkg.sv
hw/msr_ctrl.sv
hw/msr_psr.sv
hw/msr_exc_regs.sv
hw/msr_rdata_sel.sv
hw/msr_unit.sv
test/msr_unit_chk.sv
test/msr_unit_tb.sv

// ==== Makefile ====
# Verilator build and run for the MSR unit testbench
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= msr_unit_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --assert --timing
FAIL_MSG  ?= Simulation failed
PASS_MSG  ?= Simulation completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Run ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/msr_unit_tb.sv ====
// Testbench for the MSR unit
// Drives APB transfers and exception pulses and checks them against a register model
// The model packs CPUID itself from the identity values set here
// Concurrent protocol checks come from the bound msr_unit_chk
// Fixed seed, so every run sees the same data

`default_nettype none

module msr_unit_tb;

   import msr_pkg::*;

   localparam logic [7:0]  VER  = 8'h2a;
   localparam logic [9:0]  REV  = 10'h15b;
   localparam logic [7:0]  FEAT = 8'hc3;
   localparam logic [31:0] CORE = 32'h0000_0003;
   // Tests take about 210 cycles and the watchdog allows roughly double
   localparam int WATCHDOG_CYCLES = 400;
   localparam psr_t FLAG_MASK = 10'h0f0;
   localparam psr_t PSR_RESET = 10'h010;
   localparam exc_evt_t NO_EVT = '0;

   logic     clk;
   logic     rst;
   logic     psel;
   logic     penable;
   logic     pwrite;
   word_t    paddr;
   word_t    pwdata;
   word_t    prdata;
   logic     pready;
   logic     pslverr;
   exc_evt_t evt;
   psr_t     psr;
   word_t    epc;

   // Register model
   psr_t   m_psr;
   psr_t   m_epsr;
   word_t  m_epc;
   word_t  m_elsa;
   integer seed;
   int     errors;

   msr_unit #(
      .CPUID_VER  (VER),
      .CPUID_REV  (REV),
      .CPUID_FEAT (FEAT),
      .CORE_ID    (CORE)
   ) u_dut (
      .clk     (clk),
      .rst     (rst),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .evt     (evt),
      .psr     (psr),
      .epc     (epc)
   );

   always #50 clk = ~clk;

   function automatic exc_evt_t make_event(input logic ent, input logic ret,
                                           input word_t pc, input word_t lsa);
      exc_evt_t e;
      e.ent = ent;
      e.ret = ret;
      e.pc  = pc;
      e.lsa = lsa;
      return e;
   endfunction

   // Expected read word per index
   function automatic word_t expected_word(input msr_idx_t idx);
      case (idx)
         MSR_PSR:    return {22'b0, m_psr};
         // Version at bit 0, revision at bit 8, features at bit 18
         MSR_CPUID:  return (word_t'(FEAT) << 18) | (word_t'(REV) << 8) | word_t'(VER);
         MSR_EPSR:   return {22'b0, m_epsr};
         MSR_EPC:    return m_epc;
         MSR_ELSA:   return m_elsa;
         MSR_COREID: return CORE;
         default:    return 32'h0;
      endcase
   endfunction

   // Entry beats return when both are set
   task automatic apply_event(input exc_evt_t e);
      if (e.ent) begin
         m_epsr = m_psr;
         m_psr  = PSR_RESET;
         m_epc  = e.pc;
         m_elsa = e.lsa;
      end else if (e.ret) begin
         m_psr = m_epsr;
      end
   endtask

   task automatic apply_write(input msr_idx_t idx, input word_t data);
      case (idx)
         MSR_PSR:  m_psr  = data[9:0] & FLAG_MASK;
         MSR_EPSR: m_epsr = data[9:0] & FLAG_MASK;
         MSR_EPC:  m_epc  = data;
         MSR_ELSA: m_elsa = data;
         default:  ;
      endcase
   endtask

   // One APB transfer with an optional event pulse in the first ACCESS cycle
   task automatic apb_xfer(input logic wr_en, input msr_idx_t idx, input word_t data,
                           input exc_evt_t evt_acc, output word_t rdata, output logic err);
      int   stalls;
      logic done;
      stalls = 0;
      done   = 1'b0;
      @(posedge clk);
      #10;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr_en;
      paddr   = {27'b0, idx, 2'b00};
      pwdata  = data;
      @(posedge clk);
      #10;
      penable = 1'b1;
      evt     = evt_acc;
      while (!done) begin
         @(negedge clk);
         if (pready) begin
            done  = 1'b1;
            rdata = prdata;
            err   = pslverr;
         end else begin
            stalls++;
         end
         @(posedge clk);
         #10;
         evt = '0;
      end
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      // Event lands one edge before the transfer completes
      apply_event(evt_acc);
      assert (stalls == ((evt_acc.ent | evt_acc.ret) ? 1 : 0)) else begin
         errors++;
         $display("Fail pready wait cycles: got %h expected %h", stalls,
                  (evt_acc.ent | evt_acc.ret) ? 1 : 0);
      end
   endtask

   task automatic write_reg(input msr_idx_t idx, input word_t data, input exc_evt_t evt_acc);
      word_t rdata;
      logic  err;
      logic  exp_err;
      exp_err = (idx == MSR_CPUID) || (idx == MSR_COREID) || (idx > MSR_COREID);
      apb_xfer(1'b1, idx, data, evt_acc, rdata, err);
      assert (err == exp_err) else begin
         errors++;
         $display("Fail pslverr write idx %0d: got %h expected %h", idx, err, exp_err);
      end
      if (!exp_err) begin
         apply_write(idx, data);
      end
   endtask

   task automatic read_reg(input msr_idx_t idx, input exc_evt_t evt_acc);
      word_t rdata;
      logic  err;
      apb_xfer(1'b0, idx, 32'h0, evt_acc, rdata, err);
      assert (rdata == expected_word(idx)) else begin
         errors++;
         $display("Fail prdata idx %0d: got %h expected %h", idx, rdata, expected_word(idx));
      end
      assert (err == (idx > MSR_COREID)) else begin
         errors++;
         $display("Fail pslverr read idx %0d: got %h expected %h", idx, err,
                  idx > MSR_COREID);
      end
   endtask

   // Pipeline outputs sampled mid-cycle with the bus idle
   task automatic check_outputs();
      @(negedge clk);
      assert (psr == m_psr) else begin
         errors++;
         $display("Fail psr: got %h expected %h", psr, m_psr);
      end
      assert (epc == m_epc) else begin
         errors++;
         $display("Fail epc: got %h expected %h", epc, m_epc);
      end
      assert (!pready) else begin
         errors++;
         $display("Fail pready: got %h expected %h", pready, 1'b0);
      end
   endtask

   task automatic pulse_event(input logic ent, input logic ret, input word_t pc,
                              input word_t lsa);
      exc_evt_t e;
      e = make_event(ent, ret, pc, lsa);
      @(posedge clk);
      #10;
      evt = e;
      @(posedge clk);
      #10;
      evt = '0;
      apply_event(e);
      check_outputs();
   endtask

   task automatic read_all(input int count);
      for (int i = 0; i < count; i++) begin
         read_reg(msr_idx_t'(i), NO_EVT);
      end
   endtask

   initial begin
      word_t    data;
      word_t    pc;
      word_t    lsa;
      msr_idx_t idx;
      seed    = 32'ha75ed171;
      errors  = 0;
      clk     = 1'b0;
      rst     = 1'b1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      evt     = '0;
      m_psr   = PSR_RESET;
      m_epsr  = '0;
      m_epc   = '0;
      m_elsa  = '0;
      repeat (3) @(posedge clk);
      #10;
      rst = 1'b0;

      // Reset values, identity words, unmapped reads
      check_outputs();
      read_all(8);

      // Random write and readback on the writable registers
      repeat (3) begin
         for (int k = 0; k < 5; k++) begin
            idx = msr_idx_t'(k);
            if (idx != MSR_CPUID) begin
               data = $random(seed);
               write_reg(idx, data, NO_EVT);
               read_reg(idx, NO_EVT);
            end
         end
         check_outputs();
      end

      // Read-only and unmapped writes are refused
      data = $random(seed);
      write_reg(MSR_CPUID, data, NO_EVT);
      write_reg(MSR_COREID, data, NO_EVT);
      write_reg(3'd6, data, NO_EVT);
      write_reg(3'd7, data, NO_EVT);
      read_all(8);

      // Entry from a PSR with rm clear and the other flags set
      write_reg(MSR_PSR, 32'h0000_00e0, NO_EVT);
      pc  = $random(seed);
      lsa = $random(seed);
      pulse_event(1'b1, 1'b0, pc, lsa);
      read_all(6);

      // Return and then ent with ret together
      write_reg(MSR_EPSR, 32'h0000_0060, NO_EVT);
      pulse_event(1'b0, 1'b1, pc, lsa);
      read_reg(MSR_PSR, NO_EVT);
      pc  = $random(seed);
      lsa = $random(seed);
      pulse_event(1'b1, 1'b1, pc, lsa);
      read_all(6);

      // Back-pressure makes the APB write land after the entry
      data = $random(seed);
      pc   = $random(seed);
      lsa  = $random(seed);
      write_reg(MSR_EPC, data, make_event(1'b1, 1'b0, pc, lsa));
      read_reg(MSR_EPC, NO_EVT);
      // Saved flags differ from the live PSR so the stalled read shows the return
      write_reg(MSR_EPSR, 32'h0000_00a0, NO_EVT);
      read_reg(MSR_PSR, make_event(1'b0, 1'b1, pc, lsa));
      check_outputs();

      $display("Checks done, errors: %0d", errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // Watchdog
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      errors++;
      $display("Timeout: tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
      $display("Checks done, errors: %0d", errors);
      $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== test/msr_unit_chk.sv ====
// Concurrent checks bound into every msr_unit instance
// ACCESS is taken from the bus pins as psel with penable
// Checks are off while rst is high

`default_nettype none

module msr_unit_chk (
   input wire logic              clk,
   input wire logic              rst,
   input wire logic              psel,
   input wire logic              penable,
   input wire logic              pready,
   input wire logic              pslverr,
   input wire msr_pkg::exc_evt_t evt,
   input wire msr_pkg::psr_t     psr
);

   import msr_pkg::*;

   logic in_access;
   logic evt_any;

   assign in_access = psel & penable;
   assign evt_any   = evt.ent | evt.ret;

   // No response outside ACCESS
   idle_quiet: assert property (@(posedge clk) disable iff (rst)
      !in_access |-> (!pready && !pslverr))
      else $error("pready or pslverr high outside ACCESS");

   // Entry puts the core in real mode with IRQs off
   entry_real_mode: assert property (@(posedge clk) disable iff (rst)
      evt.ent |=> (psr[PSR_RM_BIT] && !psr[PSR_IRE_BIT]))
      else $error("psr not in real mode after exception entry");

   // Event in ACCESS stalls the bus
   evt_stall: assert property (@(posedge clk) disable iff (rst)
      (in_access && evt_any) |-> !pready)
      else $error("pready high while an exception event is present");

endmodule

bind msr_unit msr_unit_chk u_chk (
   .clk     (clk),
   .rst     (rst),
   .psel    (psel),
   .penable (penable),
   .pready  (pready),
   .pslverr (pslverr),
   .evt     (evt),
   .psr     (psr)
);

`default_nettype wire

// ==== hw/msr_unit.sv ====
// MSR unit top level
// APB slave for register access, one-cycle event pulses from the pipeline
// Identity values are set here and passed to the read mux
// psr and epc are live register outputs for the pipeline

`default_nettype none

module msr_unit #(
   parameter logic [7:0]  CPUID_VER  = 8'd1,
   parameter logic [9:0]  CPUID_REV  = 10'd0,
   parameter logic [7:0]  CPUID_FEAT = 8'h00,
   parameter logic [31:0] CORE_ID    = 32'd0
) (
   input  wire logic               clk,
   input  wire logic               rst,
   // APB slave
   input  wire logic               psel,
   input  wire logic               penable,
   input  wire logic               pwrite,
   input  wire msr_pkg::word_t     paddr,
   input  wire msr_pkg::word_t     pwdata,
   output msr_pkg::word_t          prdata,
   output logic                    pready,
   output logic                    pslverr,
   // Pipeline side
   input  wire msr_pkg::exc_evt_t  evt,
   output msr_pkg::psr_t           psr,
   output msr_pkg::word_t          epc
);

   import msr_pkg::*;

   logic     exc_ent;
   logic     exc_ret;
   msr_wr_t  wr;
   msr_idx_t rd_idx;
   psr_t     epsr;
   word_t    elsa;

   msr_ctrl u_ctrl (
      .clk     (clk),
      .rst     (rst),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .evt     (evt),
      .pready  (pready),
      .pslverr (pslverr),
      .exc_ent (exc_ent),
      .exc_ret (exc_ret),
      .wr      (wr),
      .rd_idx  (rd_idx)
   );

   msr_psr u_psr (
      .clk     (clk),
      .rst     (rst),
      .exc_ent (exc_ent),
      .exc_ret (exc_ret),
      .wr      (wr),
      .epsr    (epsr),
      .psr     (psr)
   );

   // Event payload goes straight to the save registers
   msr_exc_regs u_exc_regs (
      .clk     (clk),
      .rst     (rst),
      .exc_ent (exc_ent),
      .evt_pc  (evt.pc),
      .evt_lsa (evt.lsa),
      .psr     (psr),
      .wr      (wr),
      .epsr    (epsr),
      .epc     (epc),
      .elsa    (elsa)
   );

   msr_rdata_sel #(
      .CPUID_VER  (CPUID_VER),
      .CPUID_REV  (CPUID_REV),
      .CPUID_FEAT (CPUID_FEAT),
      .CORE_ID    (CORE_ID)
   ) u_rdata_sel (
      .rd_idx (rd_idx),
      .psr    (psr),
      .epsr   (epsr),
      .epc    (epc),
      .elsa   (elsa),
      .prdata (prdata)
   );

endmodule

`default_nettype wire

// ==== hw/msr_rdata_sel.sv ====
// APB read mux and identity words
// CPUID packs version [7:0], revision [17:8], features [25:18]
// Unmapped indices read zero

`default_nettype none

module msr_rdata_sel #(
   parameter logic [7:0]  CPUID_VER  = 8'd1,
   parameter logic [9:0]  CPUID_REV  = 10'd0,
   parameter logic [7:0]  CPUID_FEAT = 8'h00,
   parameter logic [31:0] CORE_ID    = 32'd0
) (
   input  wire msr_pkg::msr_idx_t rd_idx,
   input  wire msr_pkg::psr_t     psr,
   input  wire msr_pkg::psr_t     epsr,
   input  wire msr_pkg::word_t    epc,
   input  wire msr_pkg::word_t    elsa,
   output msr_pkg::word_t         prdata
);

   import msr_pkg::*;

   localparam int PSR_PAD = $bits(word_t) - $bits(psr_t);

   word_t cpuid;
   word_t coreid;

   // Identity words, constant per build
   assign cpuid  = {6'b0, CPUID_FEAT, CPUID_REV, CPUID_VER};
   assign coreid = CORE_ID;

   always_comb begin
      case (rd_idx)
         MSR_PSR:    prdata = {{PSR_PAD{1'b0}}, psr};
         MSR_CPUID:  prdata = cpuid;
         MSR_EPSR:   prdata = {{PSR_PAD{1'b0}}, epsr};
         MSR_EPC:    prdata = epc;
         MSR_ELSA:   prdata = elsa;
         MSR_COREID: prdata = coreid;
         // Indices 6 and 7
         default:    prdata = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== hw/msr_exc_regs.sv ====
// EPSR, EPC and ELSA
// Entry captures PSR, event pc and lsa in one edge
// APB writes to EPSR keep only the four flag bits

`default_nettype none

module msr_exc_regs (
   input  wire logic              clk,
   input  wire logic              rst,
   input  wire logic              exc_ent,
   input  wire msr_pkg::word_t    evt_pc,
   input  wire msr_pkg::word_t    evt_lsa,
   input  wire msr_pkg::psr_t     psr,
   input  wire msr_pkg::msr_wr_t  wr,
   output msr_pkg::psr_t          epsr,
   output msr_pkg::word_t         epc,
   output msr_pkg::word_t         elsa
);

   import msr_pkg::*;

   psr_t epsr_wdata;

   // Flag bits of the write data
   always_comb begin
      epsr_wdata               = '0;
      epsr_wdata[PSR_RM_BIT]   = wr.wdata[PSR_RM_BIT];
      epsr_wdata[PSR_IRE_BIT]  = wr.wdata[PSR_IRE_BIT];
      epsr_wdata[PSR_IMME_BIT] = wr.wdata[PSR_IMME_BIT];
      epsr_wdata[PSR_DMME_BIT] = wr.wdata[PSR_DMME_BIT];
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         epsr <= '0;
         epc  <= '0;
         elsa <= '0;
      end else if (exc_ent) begin
         // Save state at exception entry
         epsr <= psr;
         epc  <= evt_pc;
         elsa <= evt_lsa;
      end else begin
         if (wr.epsr_we) begin
            epsr <= epsr_wdata;
         end
         if (wr.epc_we) begin
            epc <= wr.wdata;
         end
         if (wr.elsa_we) begin
            elsa <= wr.wdata;
         end
      end
   end

endmodule

`default_nettype wire

// ==== hw/msr_psr.sv ====
// PSR flag registers
// Reset leaves only rm set
// Priority is entry, then return, then APB write

`default_nettype none

module msr_psr (
   input  wire logic              clk,
   input  wire logic              rst,
   input  wire logic              exc_ent,
   input  wire logic              exc_ret,
   input  wire msr_pkg::msr_wr_t  wr,
   input  wire msr_pkg::psr_t     epsr,
   output msr_pkg::psr_t          psr
);

   import msr_pkg::*;

   logic rm;
   logic ire;
   logic imme;
   logic dmme;

   always_ff @(posedge clk) begin
      if (rst) begin
         rm   <= 1'b1;
         ire  <= 1'b0;
         imme <= 1'b0;
         dmme <= 1'b0;
      end else if (exc_ent) begin
         // Enter real mode, IRQs and MMUs off
         rm   <= 1'b1;
         ire  <= 1'b0;
         imme <= 1'b0;
         dmme <= 1'b0;
      end else if (exc_ret) begin
         // Restore saved flags
         rm   <= epsr[PSR_RM_BIT];
         ire  <= epsr[PSR_IRE_BIT];
         imme <= epsr[PSR_IMME_BIT];
         dmme <= epsr[PSR_DMME_BIT];
      end else if (wr.psr_we) begin
         rm   <= wr.wdata[PSR_RM_BIT];
         ire  <= wr.wdata[PSR_IRE_BIT];
         imme <= wr.wdata[PSR_IMME_BIT];
         dmme <= wr.wdata[PSR_DMME_BIT];
      end
   end

   // Pack image, unused bits zero
   always_comb begin
      psr               = '0;
      psr[PSR_RM_BIT]   = rm;
      psr[PSR_IRE_BIT]  = ire;
      psr[PSR_IMME_BIT] = imme;
      psr[PSR_DMME_BIT] = dmme;
   end

endmodule

`default_nettype wire

// ==== hw/msr_ctrl.sv ====
// APB slave control for the MSR unit
// Two-cycle transfers; pready drops for one cycle if an event coincides
// with ACCESS, so register writes never race an exception update
// pslverr on writes to CPUID/COREID and on any index above 5
// Entry wins when ent and ret arrive together

`default_nettype none

module msr_ctrl (
   input  wire logic               clk,
   input  wire logic               rst,
   input  wire logic               psel,
   input  wire logic               penable,
   input  wire logic               pwrite,
   input  wire msr_pkg::word_t     paddr,
   input  wire msr_pkg::word_t     pwdata,
   input  wire msr_pkg::exc_evt_t  evt,
   output logic                    pready,
   output logic                    pslverr,
   output logic                    exc_ent,
   output logic                    exc_ret,
   output msr_pkg::msr_wr_t        wr,
   output msr_pkg::msr_idx_t       rd_idx
);

   import msr_pkg::*;

   apb_st_t  st;
   apb_st_t  st_nxt;
   msr_idx_t idx;
   logic     access;
   logic     evt_any;
   logic     ro_hit;
   logic     unmapped;
   logic     err;
   logic     wr_ok;

   // Word index within the register window
   assign idx    = paddr[4:2];
   assign rd_idx = idx;

   // Cleaned event strobes
   assign exc_ent = evt.ent;
   assign exc_ret = evt.ret & ~evt.ent;
   assign evt_any = evt.ent | evt.ret;

   // Access phase only counts after a setup or a stalled access
   assign access = psel & penable & ((st == SETUP) || (st == ACCESS));

   // Back-pressure while an event is being applied
   assign pready = access & ~evt_any;

   // Error decode
   assign unmapped = (idx > MSR_COREID);
   assign ro_hit   = pwrite & ((idx == MSR_CPUID) || (idx == MSR_COREID));
   assign err      = unmapped | ro_hit;
   assign pslverr  = pready & err;

   // Legal write completing this cycle
   assign wr_ok = pready & pwrite & ~err;

   // Write strobes, one at most
   always_comb begin
      wr         = '0;
      wr.wdata   = pwdata;
      wr.psr_we  = wr_ok & (idx == MSR_PSR);
      wr.epsr_we = wr_ok & (idx == MSR_EPSR);
      wr.epc_we  = wr_ok & (idx == MSR_EPC);
      wr.elsa_we = wr_ok & (idx == MSR_ELSA);
   end

   // Phase tracking
   always_comb begin
      if (psel && !penable) begin
         st_nxt = SETUP;
      end else if (access && !pready) begin
         // Stalled access, stay in ACCESS
         st_nxt = ACCESS;
      end else begin
         st_nxt = IDLE;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         st <= IDLE;
      end else begin
         st <= st_nxt;
      end
   end

endmodule

`default_nettype wire

// ==== hw/msr_pkg.sv ====
// Shared types and constants for the machine-special-register unit
// Register index comes from paddr[4:2]; other address bits are ignored
// PSR image is 10 bits wide with flags in bits 7..4 and zeros elsewhere
// Exception events are one-cycle pulses with no handshake

`default_nettype none

package msr_pkg;

   // Data word for APB data and the 32-bit registers
   typedef logic [31:0] word_t;

   // PSR image with flags in bits 7..4
   typedef logic [9:0] psr_t;

   // Register index from paddr[4:2]
   typedef logic [2:0] msr_idx_t;

   // Register map
   localparam msr_idx_t MSR_PSR    = 3'd0;
   localparam msr_idx_t MSR_CPUID  = 3'd1;
   localparam msr_idx_t MSR_EPSR   = 3'd2;
   localparam msr_idx_t MSR_EPC    = 3'd3;
   localparam msr_idx_t MSR_ELSA   = 3'd4;
   localparam msr_idx_t MSR_COREID = 3'd5;

   // PSR flag positions
   localparam logic [3:0] PSR_RM_BIT   = 4'd4;
   localparam logic [3:0] PSR_IRE_BIT  = 4'd5;
   localparam logic [3:0] PSR_IMME_BIT = 4'd6;
   localparam logic [3:0] PSR_DMME_BIT = 4'd7;

   // Exception event from the pipeline
   typedef struct packed {
      logic  ent;
      logic  ret;
      word_t pc;
      word_t lsa;
   } exc_evt_t;

   // One write into the register file
   typedef struct packed {
      logic  psr_we;
      logic  epsr_we;
      logic  epc_we;
      logic  elsa_we;
      word_t wdata;
   } msr_wr_t;

   // APB phase seen at the previous edge
   typedef enum logic [1:0] {
      IDLE,
      SETUP,
      ACCESS
   } apb_st_t;

endpackage

`default_nettype wire
